// File: ci_defines.svh
`ifndef CI_DEFINES_SVH
`define CI_DEFINES_SVH

// Window geometry, radius 6
`define CI_WIN     13
`define CI_CENTER  6
`define CI_AREA    169

// Column and band counter width
`define CI_CNT_W   10

// APB bus widths
`define CI_APB_AW  8
`define CI_APB_DW  32

// Register map
`define CI_REG_CTRL    8'h00
`define CI_REG_COLS    8'h04
`define CI_REG_BANDS   8'h08
`define CI_REG_STATUS  8'h0C
`define CI_REG_ONES    8'h10

`endif

// File: ci_pkg.sv
`include "ci_defines.svh"

package ci_pkg;

  ////////////////////////////////////////
  // Pixel data
  ////////////////////////////////////////

  typedef logic [7:0] pix_t;

  // Element 0 is the top row of the column
  typedef pix_t [`CI_WIN-1:0] pix_col_t;

  // Sum of 13 pixels, at most 3315
  typedef logic [11:0] col_sum_t;

  // Sum of 169 pixels, at most 43095
  typedef logic [15:0] win_sum_t;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  typedef logic [`CI_CNT_W-1:0] cnt_t;

  typedef logic [`CI_APB_AW-1:0] apb_addr_t;
  typedef logic [`CI_APB_DW-1:0] apb_data_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ci_state_e;

endpackage

// File: ci_if.sv
// Configuration and status between register block and controller
interface ci_cfg_if
  import ci_pkg::*;
();
  logic enable;
  logic clear;
  cnt_t cols;
  cnt_t bands;
  logic busy;
  logic frame_done_pulse;

  modport regs (output enable, clear, cols, bands, input busy, frame_done_pulse);
  modport ctrl (input enable, clear, cols, bands, output busy, frame_done_pulse);
endinterface

// Column strobes from controller to datapath
interface ci_win_if;
  logic accept;
  logic band_start;
  logic emit;
  // Drops results still in the pipeline
  logic flush;

  modport ctrl (output accept, band_start, emit, flush);
  modport dp (input accept, band_start, emit, flush);
endinterface

// File: ci_regs.sv
`include "ci_defines.svh"

module ci_regs
  import ci_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_psel,
  input  logic      i_penable,
  input  logic      i_pwrite,
  input  apb_addr_t i_paddr,
  input  apb_data_t i_pwdata,
  output apb_data_t o_prdata,
  output logic      o_pready,
  output logic      o_pslverr,
  input  logic      i_ci_valid,
  input  logic      i_ci,
  ci_cfg_if.regs    cfg
);

  logic      access;
  logic      wr_en;
  logic      addr_hit;
  apb_data_t rd_data;

  logic      enable_q;
  logic      clear_q;
  cnt_t      cols_q;
  cnt_t      bands_q;
  logic      done_q;
  apb_data_t ones_q;

  assign access = i_psel && i_penable;
  assign wr_en  = access && i_pwrite && addr_hit;

  ////////////////////////////////////////
  // Read mux and address decode
  ////////////////////////////////////////

  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (i_paddr)
      `CI_REG_CTRL:   rd_data = apb_data_t'(enable_q);
      `CI_REG_COLS:   rd_data = apb_data_t'(cols_q);
      `CI_REG_BANDS:  rd_data = apb_data_t'(bands_q);
      `CI_REG_STATUS: rd_data = apb_data_t'({cfg.busy, done_q});
      `CI_REG_ONES:   rd_data = ones_q;
      default:        addr_hit = 1'b0;
    endcase
  end

  assign o_prdata  = (access && !i_pwrite) ? rd_data : '0;
  assign o_pready  = 1'b1;
  assign o_pslverr = access && !addr_hit;

  ////////////////////////////////////////
  // Control and geometry
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_q <= 1'b0;
      clear_q  <= 1'b0;
      cols_q   <= '0;
      bands_q  <= '0;
    end else begin
      clear_q <= 1'b0;
      if (wr_en) begin
        case (i_paddr)
          `CI_REG_CTRL: begin
            // Soft clear also disables
            clear_q  <= i_pwdata[1];
            enable_q <= i_pwdata[0] && !i_pwdata[1];
          end
          `CI_REG_COLS:  cols_q <= i_pwdata[`CI_CNT_W-1:0];
          `CI_REG_BANDS: bands_q <= i_pwdata[`CI_CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Sticky frame done, write 1 to clear
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (cfg.frame_done_pulse) begin
      done_q <= 1'b1;
    end else if (wr_en && i_paddr == `CI_REG_STATUS && i_pwdata[0]) begin
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ones_q <= '0;
    end else if (clear_q) begin
      ones_q <= '0;
    end else if (i_ci_valid && i_ci) begin
      ones_q <= ones_q + 1'b1;
    end
  end

  assign cfg.enable = enable_q;
  assign cfg.clear  = clear_q;
  assign cfg.cols   = cols_q;
  assign cfg.bands  = bands_q;

  // Access phase always follows its setup phase
  a_apb_access : assert property (@(posedge clk) disable iff (!rst_n)
    i_penable |-> i_psel && $past(i_psel && !i_penable));

endmodule

// File: ci_ctrl.sv
`include "ci_defines.svh"

module ci_ctrl
  import ci_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   i_col_valid,
  output logic   o_col_ready,
  ci_cfg_if.ctrl cfg,
  ci_win_if.ctrl win
);

  ci_state_e  state;
  cnt_t       col_cnt;
  cnt_t       band_cnt;
  logic       start_ok;
  logic       abort;
  logic       col_last;
  logic       band_last;
  logic       last_emit;
  logic [2:0] done_dly;

  assign start_ok  = cfg.enable && !cfg.clear && (cfg.cols >= `CI_WIN) && (cfg.bands != '0);
  assign abort     = !cfg.enable || cfg.clear;
  assign col_last  = (col_cnt == cfg.cols - 1'b1);
  assign band_last = (band_cnt == cfg.bands - 1'b1);

  ////////////////////////////////////////
  // Column strobes
  ////////////////////////////////////////

  assign o_col_ready    = (state == RUN);
  assign win.accept     = i_col_valid && o_col_ready;
  assign win.band_start = win.accept && (col_cnt == '0);
  assign win.emit       = win.accept && (col_cnt >= `CI_WIN - 1);
  assign win.flush      = abort;

  assign last_emit = win.emit && col_last && band_last;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      col_cnt  <= '0;
      band_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          col_cnt  <= '0;
          band_cnt <= '0;
          if (start_ok) begin
            state <= RUN;
          end
        end
        RUN: begin
          if (abort) begin
            // Partial band is dropped
            state <= IDLE;
          end else if (win.accept) begin
            if (col_last) begin
              col_cnt <= '0;
              if (band_last) begin
                state <= DONE;
              end else begin
                band_cnt <= band_cnt + 1'b1;
              end
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Lines up with the final result of the frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_dly <= '0;
    end else if (abort) begin
      done_dly <= '0;
    end else begin
      done_dly <= {done_dly[1:0], last_emit};
    end
  end

  assign cfg.frame_done_pulse = done_dly[2];
  assign cfg.busy             = (state != IDLE);

  a_cnt_range : assert property (@(posedge clk) disable iff (!rst_n)
    (state == RUN) |-> (col_cnt < cfg.cols) && (band_cnt < cfg.bands));

endmodule

// File: ci_window_sum.sv
`include "ci_defines.svh"

module ci_window_sum
  import ci_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  pix_col_t i_col,
  ci_win_if.dp     win,
  output logic     o_ci_valid,
  output logic     o_ci
);

  col_sum_t             col_sum;
  col_sum_t             hist [`CI_WIN];
  logic [`CI_WIN-1:0]   hist_vld;
  win_sum_t             leave;
  win_sum_t             win_sum;
  pix_t                 ctr_dly [`CI_CENTER+1];

  logic                 emit_q1;
  logic                 emit_q2;
  win_sum_t             prod_q;
  win_sum_t             sum_q;

  ////////////////////////////////////////
  // Stage 1, column sums
  ////////////////////////////////////////

  always_comb begin
    col_sum = '0;
    for (int r = 0; r < `CI_WIN; r++) begin
      col_sum = col_sum + col_sum_t'(i_col[r]);
    end
  end

  // Oldest column leaves only once the window is full
  assign leave = hist_vld[`CI_WIN-1] ? win_sum_t'(hist[`CI_WIN-1]) : '0;

  always_ff @(posedge clk) begin
    if (win.accept) begin
      hist[0] <= col_sum;
      for (int i = 1; i < `CI_WIN; i++) begin
        hist[i] <= hist[i-1];
      end
      if (win.band_start) begin
        win_sum <= win_sum_t'(col_sum);
      end else begin
        win_sum <= win_sum + win_sum_t'(col_sum) - leave;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hist_vld <= '0;
    end else if (win.accept) begin
      if (win.band_start) begin
        hist_vld <= {{(`CI_WIN-1){1'b0}}, 1'b1};
      end else begin
        hist_vld <= {hist_vld[`CI_WIN-2:0], 1'b1};
      end
    end
  end

  // Center row, 6 columns back after the shift
  always_ff @(posedge clk) begin
    if (win.accept) begin
      ctr_dly[0] <= i_col[`CI_CENTER];
      for (int i = 1; i <= `CI_CENTER; i++) begin
        ctr_dly[i] <= ctr_dly[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // Stage 2, compare against the mean
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (emit_q1) begin
      prod_q <= win_sum_t'(ctr_dly[`CI_CENTER]) * win_sum_t'(`CI_AREA);
      sum_q  <= win_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      emit_q1    <= 1'b0;
      emit_q2    <= 1'b0;
      o_ci_valid <= 1'b0;
      o_ci       <= 1'b0;
    end else if (win.flush) begin
      emit_q1    <= 1'b0;
      emit_q2    <= 1'b0;
      o_ci_valid <= 1'b0;
    end else begin
      emit_q1    <= win.emit;
      emit_q2    <= emit_q1;
      o_ci_valid <= emit_q2;
      if (emit_q2) begin
        o_ci <= (prod_q >= sum_q);
      end
    end
  end

  // Needs 12 earlier columns of the same band
  a_emit_full : assert property (@(posedge clk) disable iff (!rst_n)
    win.emit |-> !win.band_start && hist_vld[`CI_WIN-2]);

endmodule

// File: ci_top.sv
module ci_top
  import ci_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // APB slave
  input  logic      i_psel,
  input  logic      i_penable,
  input  logic      i_pwrite,
  input  apb_addr_t i_paddr,
  input  apb_data_t i_pwdata,
  output apb_data_t o_prdata,
  output logic      o_pready,
  output logic      o_pslverr,

  // Column stream
  input  logic      i_col_valid,
  input  pix_col_t  i_col,
  output logic      o_col_ready,

  // Results
  output logic      o_ci_valid,
  output logic      o_ci,
  output logic      o_frame_done
);

  logic ci_valid;
  logic ci;

  ci_cfg_if cfg_if ();
  ci_win_if win_if ();

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  ci_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .i_ci_valid (ci_valid),
    .i_ci       (ci),
    .cfg        (cfg_if.regs)
  );

  ci_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col_valid (i_col_valid),
    .o_col_ready (o_col_ready),
    .cfg         (cfg_if.ctrl),
    .win         (win_if.ctrl)
  );

  ci_window_sum u_window_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_col      (i_col),
    .win        (win_if.dp),
    .o_ci_valid (ci_valid),
    .o_ci       (ci)
  );

  assign o_ci_valid = ci_valid;
  assign o_ci       = ci;

  // One cycle after the last result, same edge as the status flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= cfg_if.frame_done_pulse;
    end
  end

endmodule

// File: tb_ci_top.sv
`include "ci_defines.svh"

module tb_ci_top
  import ci_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // Flat, random, gapped, partial plus refill
  localparam int TOTAL_COLS = 32 + 60 + 60 + 20 + 40;
  localparam int WATCHDOG_CYCLES = TOTAL_COLS * 4 + 2000;

  logic      clk;
  logic      rst_n;
  logic      i_psel;
  logic      i_penable;
  logic      i_pwrite;
  apb_addr_t i_paddr;
  apb_data_t i_pwdata;
  apb_data_t o_prdata;
  logic      o_pready;
  logic      o_pslverr;
  logic      i_col_valid;
  pix_col_t  i_col;
  logic      o_col_ready;
  logic      o_ci_valid;
  logic      o_ci;
  logic      o_frame_done;

  integer    seed;
  int        errors;
  int        cycle;
  int        last_cyc;
  int        n_results;
  int        exp_ones;
  logic      exp_bit [$];
  int        exp_cyc [$];
  pix_col_t  band_buf [64];
  pix_col_t  frame_mem [256];

  ci_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////
  // Checks and result monitor
  ////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && o_ci_valid) begin
      n_results++;
      last_cyc = cycle;
      if (exp_bit.size() == 0) begin
        errors++;
        $display("Result at time %0t has no completing column", $time);
      end else begin
        check("o_ci", exp_bit.pop_front(), o_ci);
        check("result cycle", exp_cyc.pop_front(), cycle);
      end
    end
  end

  // Center of the window that ends at column idx against the 169-pixel sum
  function automatic logic window_ci(input int idx);
    int sum;
    int center;
    sum = 0;
    for (int j = idx - `CI_WIN + 1; j <= idx; j++) begin
      for (int r = 0; r < `CI_WIN; r++) begin
        sum += band_buf[j][r];
      end
    end
    center = band_buf[idx - `CI_CENTER][`CI_CENTER];
    return (center * `CI_AREA) >= sum;
  endfunction

  ////////////////////////////////////////
  // Bus and stream tasks
  ////////////////////////////////////////

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(negedge clk);
    i_psel   = 1'b1;
    i_pwrite = 1'b1;
    i_paddr  = addr;
    i_pwdata = data;
    @(negedge clk);
    i_penable = 1'b1;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge clk);
    i_psel   = 1'b1;
    i_pwrite = 1'b0;
    i_paddr  = addr;
    @(negedge clk);
    i_penable = 1'b1;
    #(CLK_PERIOD / 4);
    data = o_prdata;
    err  = o_pslverr;
    check("o_pready", 1, o_pready);
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic reg_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t data;
    logic      err;
    apb_read(addr, data, err);
    check(name, exp, data);
    check({name, " pslverr"}, 0, err);
  endtask

  task automatic send_column(input pix_col_t col, input int idx);
    logic bit_exp;
    @(negedge clk);
    i_col_valid = 1'b1;
    i_col       = col;
    while (!o_col_ready) @(negedge clk);
    band_buf[idx] = col;
    if (idx >= `CI_WIN - 1) begin
      bit_exp = window_ci(idx);
      exp_bit.push_back(bit_exp);
      // Accepted on the next edge, result visible two edges later
      exp_cyc.push_back(cycle + 3);
      exp_ones += bit_exp;
    end
    @(posedge clk);
  endtask

  task automatic send_band(input int base, input int cols, input int gap_max);
    int gap;
    for (int c = 0; c < cols; c++) begin
      gap = (gap_max > 0) ? $unsigned($random(seed)) % (gap_max + 1) : 0;
      repeat (gap) begin
        @(negedge clk);
        i_col_valid = 1'b0;
      end
      send_column(frame_mem[base + c], c);
    end
  endtask

  task automatic expect_results(input int max_cycles);
    int n;
    n = 0;
    while (exp_bit.size() > 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (exp_bit.size() > 0) begin
      errors++;
      $display("%0d results never arrived by time %0t", exp_bit.size(), $time);
    end
  endtask

  ////////////////////////////////////////
  // Frame level
  ////////////////////////////////////////

  task automatic fill_frame(input int cols, input int bands, input logic flat);
    for (int i = 0; i < cols * bands; i++) begin
      for (int r = 0; r < `CI_WIN; r++) begin
        frame_mem[i][r] = flat ? 8'd100 : pix_t'($random(seed));
      end
    end
  endtask

  task automatic start_frame(input int cols, input int bands);
    apb_write(`CI_REG_CTRL, 32'h2);
    apb_write(`CI_REG_COLS, cols);
    apb_write(`CI_REG_BANDS, bands);
    apb_write(`CI_REG_CTRL, 32'h1);
    exp_ones  = 0;
    n_results = 0;
  endtask

  task automatic run_frame(input int cols, input int bands, input int gap_max);
    apb_data_t data;
    logic      err;
    int        n;
    for (int b = 0; b < bands; b++) begin
      send_band(b * cols, cols, gap_max);
    end
    @(negedge clk);
    i_col_valid = 1'b0;
    n = 0;
    while (!o_frame_done && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!o_frame_done) begin
      errors++;
      $display("Frame done never pulsed after the last column");
    end
    // One cycle after the final result
    check("o_frame_done cycle", last_cyc + 1, cycle);
    check("results left at frame done", 0, exp_bit.size());
    check("result count", bands * (cols - `CI_WIN + 1), n_results);
    @(negedge clk);
    check("o_frame_done pulse", 0, o_frame_done);
    reg_expect(`CI_REG_ONES, exp_ones, "ONES");
    apb_read(`CI_REG_STATUS, data, err);
    check("STATUS frame done", 1, data[0]);
    apb_write(`CI_REG_STATUS, 32'h1);
    apb_read(`CI_REG_STATUS, data, err);
    check("STATUS frame done cleared", 0, data[0]);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_registers();
    apb_data_t data;
    logic      err;
    reg_expect(`CI_REG_CTRL, 0, "CTRL");
    reg_expect(`CI_REG_COLS, 0, "COLS");
    reg_expect(`CI_REG_BANDS, 0, "BANDS");
    reg_expect(`CI_REG_STATUS, 0, "STATUS");
    reg_expect(`CI_REG_ONES, 0, "ONES");
    apb_write(`CI_REG_COLS, 16);
    apb_write(`CI_REG_BANDS, 2);
    reg_expect(`CI_REG_COLS, 16, "COLS");
    reg_expect(`CI_REG_BANDS, 2, "BANDS");
    apb_read(8'h14, data, err);
    check("unmapped pslverr", 1, err);
    check("unmapped prdata", 0, data);
    check("o_col_ready while disabled", 0, o_col_ready);
  endtask

  // Flat image, every window sits at its mean
  task automatic test_flat();
    fill_frame(16, 2, 1'b1);
    start_frame(16, 2);
    run_frame(16, 2, 0);
    reg_expect(`CI_REG_ONES, 2 * (16 - `CI_WIN + 1), "ONES flat");
  endtask

  task automatic test_random();
    fill_frame(20, 3, 1'b0);
    start_frame(20, 3);
    run_frame(20, 3, 0);
  endtask

  // Same image again with gaps on the column stream
  task automatic test_gaps();
    start_frame(20, 3);
    run_frame(20, 3, 3);
  endtask

  task automatic test_clear();
    fill_frame(30, 2, 1'b1);
    start_frame(30, 2);
    for (int c = 0; c < 20; c++) begin
      send_column(frame_mem[c], c);
    end
    @(negedge clk);
    i_col_valid = 1'b0;
    expect_results(20);
    reg_expect(`CI_REG_ONES, 20 - `CI_WIN + 1, "ONES before clear");
    apb_write(`CI_REG_CTRL, 32'h2);
    @(negedge clk);
    check("o_col_ready after clear", 0, o_col_ready);
    reg_expect(`CI_REG_ONES, 0, "ONES after clear");
    fill_frame(20, 2, 1'b0);
    start_frame(20, 2);
    run_frame(20, 2, 0);
  endtask

  initial begin
    seed        = 32'hf7ef3c3b;
    errors      = 0;
    cycle       = 0;
    last_cyc    = 0;
    n_results   = 0;
    exp_ones    = 0;
    rst_n       = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_col_valid = 1'b0;
    i_col       = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_registers();
    test_flat();
    test_random();
    test_gaps();
    test_clear();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
ci_pkg.sv
ci_if.sv
ci_regs.sv
ci_ctrl.sv
ci_window_sum.sv
ci_top.sv
tb_ci_top.sv

// File: Bender.yml
package:
  name: ci_mrelbp

export_include_dirs:
  - .

sources:
  - ci_pkg.sv
  - ci_if.sv
  - ci_regs.sv
  - ci_ctrl.sv
  - ci_window_sum.sv
  - ci_top.sv
  - target: test
    files:
      - tb_ci_top.sv
